//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rtc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)
	! grep -q "\*\* FAIL \*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/rtc_pkg.sv
package rtc_pkg;

    // one binary coded time or calendar field
    typedef logic [7:0] field_t;

    // address on the register write port
    typedef logic [3:0] reg_addr_t;

    // register map, addresses 6 to 15 are unused
    localparam reg_addr_t ADDR_SEC   = 4'd0;
    localparam reg_addr_t ADDR_MIN   = 4'd1;
    localparam reg_addr_t ADDR_HOUR  = 4'd2;
    localparam reg_addr_t ADDR_DAY   = 4'd3;
    localparam reg_addr_t ADDR_MONTH = 4'd4;
    localparam reg_addr_t ADDR_YEAR  = 4'd5;

    // last value before each time field wraps to zero
    localparam field_t SEC_LAST  = 8'd59;
    localparam field_t MIN_LAST  = 8'd59;
    localparam field_t HOUR_LAST = 8'd23;

    // month numbers
    localparam field_t MONTH_JAN = 8'd1;
    localparam field_t MONTH_FEB = 8'd2;
    localparam field_t MONTH_MAR = 8'd3;
    localparam field_t MONTH_APR = 8'd4;
    localparam field_t MONTH_MAY = 8'd5;
    localparam field_t MONTH_JUN = 8'd6;
    localparam field_t MONTH_JUL = 8'd7;
    localparam field_t MONTH_AUG = 8'd8;
    localparam field_t MONTH_SEP = 8'd9;
    localparam field_t MONTH_OCT = 8'd10;
    localparam field_t MONTH_NOV = 8'd11;
    localparam field_t MONTH_DEC = 8'd12;

    // days are counted from one
    localparam field_t DAY_FIRST = 8'd1;

    // calendar after reset is 1 jan 2023, year kept as offset from 2000
    localparam field_t RESET_DAY   = 8'd1;
    localparam field_t RESET_MONTH = 8'd1;
    localparam field_t RESET_YEAR  = 8'd23;

endpackage

//--- flist.f
common/rtc_pkg.sv
source/time_of_day_counter.sv
source/calendar_counter.sv
source/rtc_top.sv
verif/tb_clock_gen.sv
verif/rtc_asserts.sv
verif/rtc_checker.sv
verif/rtc_tb.sv

//--- source/calendar_counter.sv
`timescale 1ns/1ps

module calendar_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               day_carry,
    input  logic               write_en,
    input  rtc_pkg::reg_addr_t write_addr,
    input  rtc_pkg::field_t    write_data,
    output rtc_pkg::field_t    day,
    output rtc_pkg::field_t    month,
    output rtc_pkg::field_t    year
);

    // month lengths in days
    localparam rtc_pkg::field_t LEN_LONG  = 8'd31;
    localparam rtc_pkg::field_t LEN_SHORT = 8'd30;
    localparam rtc_pkg::field_t LEN_FEB   = 8'd28;
    localparam rtc_pkg::field_t LEN_LEAP  = 8'd29;

    localparam logic [15:0] YEAR_BASE = 16'd2000;

    logic [15:0] year_full;
    logic        is_leap;

    rtc_pkg::field_t month_len;
    logic            month_valid;

    // rollover conditions from the values before this edge
    logic month_end;
    logic year_end;

    logic wr_day;
    logic wr_month;
    logic wr_year;

    rtc_pkg::field_t day_next;
    rtc_pkg::field_t month_next;
    rtc_pkg::field_t year_next;

    assign wr_day   = write_en && (write_addr == rtc_pkg::ADDR_DAY);
    assign wr_month = write_en && (write_addr == rtc_pkg::ADDR_MONTH);
    assign wr_year  = write_en && (write_addr == rtc_pkg::ADDR_YEAR);

    // leap if divisible by 4, but centuries only when divisible by 400
    assign year_full = YEAR_BASE + {8'd0, year};
    assign is_leap   = ((year_full % 16'd4) == 16'd0)
                    && (((year_full % 16'd100) != 16'd0)
                        || ((year_full % 16'd400) == 16'd0));

    always_comb begin
        month_valid = 1'b1;
        case (month)
            rtc_pkg::MONTH_JAN: month_len = LEN_LONG;
            rtc_pkg::MONTH_FEB: month_len = is_leap ? LEN_LEAP : LEN_FEB;
            rtc_pkg::MONTH_MAR: month_len = LEN_LONG;
            rtc_pkg::MONTH_APR: month_len = LEN_SHORT;
            rtc_pkg::MONTH_MAY: month_len = LEN_LONG;
            rtc_pkg::MONTH_JUN: month_len = LEN_SHORT;
            rtc_pkg::MONTH_JUL: month_len = LEN_LONG;
            rtc_pkg::MONTH_AUG: month_len = LEN_LONG;
            rtc_pkg::MONTH_SEP: month_len = LEN_SHORT;
            rtc_pkg::MONTH_OCT: month_len = LEN_LONG;
            rtc_pkg::MONTH_NOV: month_len = LEN_SHORT;
            rtc_pkg::MONTH_DEC: month_len = LEN_LONG;
            default: begin
                // bad month number, calendar holds until it is rewritten
                month_len   = '0;
                month_valid = 1'b0;
            end
        endcase
    end

    // a day written past the month end rolls over on the next carry
    assign month_end = day_carry && month_valid && (day >= month_len);
    assign year_end  = month_end && (month >= rtc_pkg::MONTH_DEC);

    always_comb begin
        day_next   = day;
        month_next = month;
        year_next  = year;

        if (day_carry && month_valid) begin
            day_next = month_end ? rtc_pkg::DAY_FIRST : day + 8'd1;
        end
        if (month_end) begin
            month_next = year_end ? rtc_pkg::MONTH_JAN : month + 8'd1;
        end
        // year offset wraps 255 to 0
        if (year_end) begin
            year_next = year + 8'd1;
        end

        if (wr_day) begin
            day_next = write_data;
        end
        if (wr_month) begin
            month_next = write_data;
        end
        if (wr_year) begin
            year_next = write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            day   <= rtc_pkg::RESET_DAY;
            month <= rtc_pkg::RESET_MONTH;
            year  <= rtc_pkg::RESET_YEAR;
        end else begin
            day   <= day_next;
            month <= month_next;
            year  <= year_next;
        end
    end

endmodule

//--- source/rtc_top.sv
`timescale 1ns/1ps

module rtc_top #(
    parameter int unsigned TICK_DIVIDE = 100_000_000
) (
    input  logic               clk,
    input  logic               reset,

    // register write strobe, always accepted
    input  logic               write_en,
    input  rtc_pkg::reg_addr_t write_addr,
    input  rtc_pkg::field_t    write_data,

    // time of day, 24 hour format
    output rtc_pkg::field_t    sec,
    output rtc_pkg::field_t    min,
    output rtc_pkg::field_t    hour,

    // calendar, year as offset from 2000
    output rtc_pkg::field_t    day,
    output rtc_pkg::field_t    month,
    output rtc_pkg::field_t    year
);

    // one cycle pulse when the hours wrap past midnight
    logic day_carry;

    time_of_day_counter #(
        .TICK_DIVIDE (TICK_DIVIDE)
    ) time_of_day_i (
        .clk        (clk),
        .reset      (reset),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .sec        (sec),
        .min        (min),
        .hour       (hour),
        .day_carry  (day_carry)
    );

    // both counters see every write and decode their own addresses
    calendar_counter calendar_i (
        .clk        (clk),
        .reset      (reset),
        .day_carry  (day_carry),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .day        (day),
        .month      (month),
        .year       (year)
    );

endmodule

//--- source/time_of_day_counter.sv
`timescale 1ns/1ps

module time_of_day_counter #(
    parameter int unsigned TICK_DIVIDE = 100_000_000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               write_en,
    input  rtc_pkg::reg_addr_t write_addr,
    input  rtc_pkg::field_t    write_data,
    output rtc_pkg::field_t    sec,
    output rtc_pkg::field_t    min,
    output rtc_pkg::field_t    hour,
    output logic               day_carry
);

    // divider just wide enough to hold TICK_DIVIDE-1
    localparam int unsigned DIV_W = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIVIDE - 1);

    logic [DIV_W-1:0] div_count;
    logic [DIV_W-1:0] div_next;
    logic             tick;

    // carry chain, all taken from the values before this edge
    logic sec_wrap;
    logic min_wrap;
    logic hour_wrap;

    // write decode for the three time fields
    logic wr_sec;
    logic wr_min;
    logic wr_hour;

    rtc_pkg::field_t sec_next;
    rtc_pkg::field_t min_next;
    rtc_pkg::field_t hour_next;

    assign wr_sec  = write_en && (write_addr == rtc_pkg::ADDR_SEC);
    assign wr_min  = write_en && (write_addr == rtc_pkg::ADDR_MIN);
    assign wr_hour = write_en && (write_addr == rtc_pkg::ADDR_HOUR);

    // one second has passed when the divider sits on its last count
    assign tick = (div_count == DIV_LAST);

    // a field above its last value also wraps, so compare with >=
    assign sec_wrap  = tick && (sec >= rtc_pkg::SEC_LAST);
    assign min_wrap  = sec_wrap && (min >= rtc_pkg::MIN_LAST);
    assign hour_wrap = min_wrap && (hour >= rtc_pkg::HOUR_LAST);

    // day carry goes to the calendar in the same cycle
    assign day_carry = hour_wrap;

    // seconds write restarts the second so the next tick is a full period away
    always_comb begin
        if (tick || wr_sec) begin
            div_next = '0;
        end else begin
            div_next = div_count + 1'b1;
        end
    end

    always_comb begin
        sec_next  = sec;
        min_next  = min;
        hour_next = hour;

        if (tick) begin
            sec_next = sec_wrap ? 8'd0 : sec + 8'd1;
        end
        if (sec_wrap) begin
            min_next = min_wrap ? 8'd0 : min + 8'd1;
        end
        if (min_wrap) begin
            hour_next = hour_wrap ? 8'd0 : hour + 8'd1;
        end

        // the written field wins over its own count
        if (wr_sec) begin
            sec_next = write_data;
        end
        if (wr_min) begin
            min_next = write_data;
        end
        if (wr_hour) begin
            hour_next = write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count <= '0;
        end else begin
            div_count <= div_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sec  <= '0;
            min  <= '0;
            hour <= '0;
        end else begin
            sec  <= sec_next;
            min  <= min_next;
            hour <= hour_next;
        end
    end

endmodule

//--- verif/rtc_asserts.sv
`timescale 1ns/1ps

module rtc_asserts (
    input logic            clk,
    input logic            reset,
    input rtc_pkg::field_t sec,
    input rtc_pkg::field_t min,
    input rtc_pkg::field_t hour,
    input rtc_pkg::field_t day,
    input rtc_pkg::field_t month
);

    sec_range: assert property (@(posedge clk) disable iff (reset) sec <= 8'd59)
        else $error("seconds out of range");
    min_range: assert property (@(posedge clk) disable iff (reset) min <= 8'd59)
        else $error("minutes out of range");
    hour_range: assert property (@(posedge clk) disable iff (reset) hour <= 8'd23)
        else $error("hours out of range");
    month_range: assert property (@(posedge clk) disable iff (reset)
        (month >= 8'd1) && (month <= 8'd12))
        else $error("month out of range");
    day_range: assert property (@(posedge clk) disable iff (reset)
        (day >= 8'd1) && (day <= 8'd31))
        else $error("day out of range");

endmodule

bind rtc_top rtc_asserts asserts_i (
    .clk   (clk),
    .reset (reset),
    .sec   (sec),
    .min   (min),
    .hour  (hour),
    .day   (day),
    .month (month)
);

//--- verif/rtc_checker.sv
`timescale 1ns/1ps

module rtc_checker #(
    parameter int TICK_DIVIDE = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               write_en,
    input  rtc_pkg::reg_addr_t write_addr,
    input  rtc_pkg::field_t    write_data,
    input  rtc_pkg::field_t    sec,
    input  rtc_pkg::field_t    min,
    input  rtc_pkg::field_t    hour,
    input  rtc_pkg::field_t    day,
    input  rtc_pkg::field_t    month,
    input  rtc_pkg::field_t    year,
    output int                 error_count
);

    int m_div;
    int m_sec, m_min, m_hour, m_day, m_month, m_year;

    initial error_count = 0;

    function automatic int days_in_month(input int mon, input int yr_offset);
        int y;
        y = 2000 + yr_offset;
        if (mon == 2) begin
            if ((y % 400 == 0) || ((y % 4 == 0) && (y % 100 != 0))) begin
                return 29;
            end
            return 28;
        end
        if (mon == 4 || mon == 6 || mon == 9 || mon == 11) begin
            return 30;
        end
        return 31;
    endfunction

    task automatic compare_field(input string name, input int expected, input logic [7:0] got);
        if (got !== 8'(expected)) begin
            $display("mismatch %s expected 0x%02h got 0x%02h", name, 8'(expected), got);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        int n_sec, n_min, n_hour, n_day, n_month, n_year;
        bit tick, carry;
        if (reset) begin
            m_div = 0;
            m_sec = 0;
            m_min = 0;
            m_hour = 0;
            m_day = 1;
            m_month = 1;
            m_year = 23;
        end else begin
            // outputs still hold the values from the previous edge here
            compare_field("sec", m_sec, sec);
            compare_field("min", m_min, min);
            compare_field("hour", m_hour, hour);
            compare_field("day", m_day, day);
            compare_field("month", m_month, month);
            compare_field("year", m_year, year);

            n_sec = m_sec;
            n_min = m_min;
            n_hour = m_hour;
            n_day = m_day;
            n_month = m_month;
            n_year = m_year;
            carry = 0;
            tick = (m_div == TICK_DIVIDE - 1);
            if (tick) begin
                n_sec = (m_sec >= 59) ? 0 : m_sec + 1;
                if (m_sec >= 59) begin
                    n_min = (m_min >= 59) ? 0 : m_min + 1;
                    if (m_min >= 59) begin
                        n_hour = (m_hour >= 23) ? 0 : m_hour + 1;
                        carry = (m_hour >= 23);
                    end
                end
            end
            if (carry && m_month >= 1 && m_month <= 12) begin
                if (m_day >= days_in_month(m_month, m_year)) begin
                    n_day = 1;
                    if (m_month == 12) begin
                        n_month = 1;
                        n_year = (m_year + 1) % 256;
                    end else begin
                        n_month = m_month + 1;
                    end
                end else begin
                    n_day = m_day + 1;
                end
            end
            m_div = (tick || (write_en && write_addr == 4'd0)) ? 0 : m_div + 1;
            if (write_en) begin
                case (write_addr)
                    4'd0: n_sec = int'(write_data);
                    4'd1: n_min = int'(write_data);
                    4'd2: n_hour = int'(write_data);
                    4'd3: n_day = int'(write_data);
                    4'd4: n_month = int'(write_data);
                    4'd5: n_year = int'(write_data);
                    default: ;
                endcase
            end
            m_sec = n_sec;
            m_min = n_min;
            m_hour = n_hour;
            m_day = n_day;
            m_month = n_month;
            m_year = n_year;
        end
    end

endmodule

//--- verif/rtc_tb.sv
`timescale 1ns/1ps

module rtc_tb;

    localparam int TICK_DIVIDE = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_OPS = 200;

    // longest run of each test in cycles
    localparam int FREE_RUN_CYCLES = 12 + 3 + 50;
    localparam int MIDNIGHT_CYCLES = 6 + 6;
    localparam int MIDNIGHT_SETUPS = 12 + 4 + 2;
    localparam int DIVIDER_CYCLES = 2 + 1 + 9 + 10 + 4;
    localparam int RANDOM_CYCLES = RANDOM_OPS * 7 + 4;
    localparam int TEST_CYCLES = RESET_CYCLES + 1 + FREE_RUN_CYCLES
                               + MIDNIGHT_SETUPS * MIDNIGHT_CYCLES
                               + DIVIDER_CYCLES + RANDOM_CYCLES;
    localparam int MARGIN_CYCLES = 500;

    logic               clk;
    logic               reset;
    logic               write_en;
    rtc_pkg::reg_addr_t write_addr;
    rtc_pkg::field_t    write_data;
    rtc_pkg::field_t    sec, min, hour, day, month, year;
    int                 error_count;
    int                 tests_run;
    int                 tests_failed;
    int                 test_start_errors;
    logic [15:0]        lfsr_state;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_gen_i (.clk(clk), .reset(reset));

    rtc_top #(.TICK_DIVIDE(TICK_DIVIDE)) dut_i (
        .clk(clk), .reset(reset), .write_en(write_en), .write_addr(write_addr),
        .write_data(write_data), .sec(sec), .min(min), .hour(hour),
        .day(day), .month(month), .year(year)
    );

    rtc_checker #(.TICK_DIVIDE(TICK_DIVIDE)) checker_i (
        .clk(clk), .reset(reset), .write_en(write_en), .write_addr(write_addr),
        .write_data(write_data), .sec(sec), .min(min), .hour(hour),
        .day(day), .month(month), .year(year), .error_count(error_count)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int unsigned value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_field(input int addr, input int data);
        write_en = 1'b1;
        write_addr = 4'(addr);
        write_data = 8'(data);
        @(posedge clk);
        #1;
        write_en = 1'b0;
    endtask

    // write the date and 23:59:59 with seconds last so the tick is 4 edges away
    task automatic set_before_midnight(input int yr, input int mon, input int dy);
        write_field(5, yr);
        write_field(4, mon);
        write_field(3, dy);
        write_field(2, 23);
        write_field(1, 59);
        write_field(0, 59);
        idle(6);
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - test_start_errors);
        end
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 10);
        $display("timeout: the tests did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int unsigned op, val;
        int mdays[12];
        int leap_years[4];
        mdays = '{31, 28, 31, 30, 31, 30, 31, 31, 30, 31, 30, 31};
        leap_years = '{0, 24, 23, 100};
        write_en = 1'b0;
        write_addr = '0;
        write_data = '0;
        lfsr_state = 16'd39;
        tests_run = 0;
        tests_failed = 0;
        @(negedge reset);
        @(posedge clk);
        #1;

        start_test();
        idle(12);
        write_field(2, 23);
        write_field(1, 59);
        write_field(0, 50);
        idle(50);
        finish_test("reset_and_free_run");

        start_test();
        for (int m = 1; m <= 12; m++) begin
            set_before_midnight(23, m, mdays[m-1]);
        end
        finish_test("month_lengths");

        start_test();
        for (int i = 0; i < 4; i++) begin
            set_before_midnight(leap_years[i], 2, 28);
        end
        finish_test("leap_years");

        start_test();
        set_before_midnight(22, 12, 31);
        set_before_midnight(255, 12, 31);
        finish_test("year_rollover");

        start_test();
        idle(2);
        write_field(0, 10);
        idle(9);
        for (int a = 6; a < 16; a++) begin
            take_bits(8, val);
            write_field(a, val);
        end
        idle(4);
        finish_test("divider_and_ignored_addresses");

        start_test();
        for (int i = 0; i < RANDOM_OPS; i++) begin
            take_bits(3, op);
            take_bits(8, val);
            case (op)
                0: write_field(0, (val[0]) ? 59 : val % 60);
                1: write_field(1, (val[0]) ? 59 : val % 60);
                2: write_field(2, (val[0]) ? 23 : val % 24);
                3: write_field(3, val % 28 + 1);
                4: write_field(4, val % 12 + 1);
                5: write_field(5, val);
                default: idle(val % 8);
            endcase
        end
        idle(4);
        finish_test("random_writes");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release reset just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule
